// ==== testbench/fpu_noncomp_tests.txt ====
# op fmt rs1 rs2 expected_result expected_fflags, all hex
# op: 0 sgnj 1 sgnjn 2 sgnjx 3 min 4 max 5 eq 6 lt 7 le 8 class, fmt: 0 single 1 double
0 0 ffffffff3f800000 ffffffffc0000000 ffffffffbf800000 00
1 0 ffffffff3f800000 ffffffffc0000000 ffffffff3f800000 00
2 0 ffffffffbf800000 ffffffffc0000000 ffffffff3f800000 00
0 1 3ff0000000000000 c000000000000000 bff0000000000000 00
1 1 bff0000000000000 4000000000000000 bff0000000000000 00
2 1 bff0000000000000 c000000000000000 3ff0000000000000 00
0 0 000000003f800000 ffffffff80000000 ffffffffffc00000 00
3 0 ffffffff3f800000 ffffffff40000000 ffffffff3f800000 00
4 0 ffffffff3f800000 ffffffff40000000 ffffffff40000000 00
3 1 bff0000000000000 3ff0000000000000 bff0000000000000 00
4 1 c000000000000000 bff0000000000000 bff0000000000000 00
3 0 ffffffff00000000 ffffffff80000000 ffffffff80000000 00
4 1 8000000000000000 0000000000000000 0000000000000000 00
3 0 ffffffff7fc00000 ffffffff40000000 ffffffff40000000 00
4 1 4000000000000000 7ff8000000000000 4000000000000000 00
3 1 7ff8000000000000 7ff0000000000001 7ff8000000000000 10
4 0 ffffffff7f800001 ffffffff3f800000 ffffffff3f800000 10
3 0 ffffffff7fc00001 ffffffff7fc00000 ffffffff7fc00000 00
5 0 ffffffff3f800000 ffffffff3f800000 0000000000000001 00
5 1 0000000000000000 8000000000000000 0000000000000001 00
6 0 ffffffffbf800000 ffffffff3f800000 0000000000000001 00
6 1 4000000000000000 3ff0000000000000 0000000000000000 00
7 1 3ff0000000000000 3ff0000000000000 0000000000000001 00
7 0 ffffffffc0000000 ffffffffbf800000 0000000000000001 00
5 0 ffffffff7fc00000 ffffffff3f800000 0000000000000000 00
5 1 7ff0000000000001 3ff0000000000000 0000000000000000 10
6 0 ffffffff7fc00000 ffffffff3f800000 0000000000000000 10
7 1 3ff0000000000000 7ff8000000000000 0000000000000000 10
8 0 ffffffffff800000 0000000000000000 0000000000000001 00
8 0 ffffffffbf800000 0000000000000000 0000000000000002 00
8 0 ffffffff80000001 0000000000000000 0000000000000004 00
8 0 ffffffff80000000 0000000000000000 0000000000000008 00
8 0 ffffffff00000000 0000000000000000 0000000000000010 00
8 0 ffffffff00000001 0000000000000000 0000000000000020 00
8 0 ffffffff3f800000 0000000000000000 0000000000000040 00
8 0 ffffffff7f800000 0000000000000000 0000000000000080 00
8 0 ffffffff7f800001 0000000000000000 0000000000000100 00
8 0 ffffffff7fc00000 0000000000000000 0000000000000200 00
8 1 fff0000000000000 0000000000000000 0000000000000001 00
8 1 bff0000000000000 0000000000000000 0000000000000002 00
8 1 8000000000000001 0000000000000000 0000000000000004 00
8 1 8000000000000000 0000000000000000 0000000000000008 00
8 1 0000000000000000 0000000000000000 0000000000000010 00
8 1 0000000000000001 0000000000000000 0000000000000020 00
8 1 3ff0000000000000 0000000000000000 0000000000000040 00
8 1 7ff0000000000000 0000000000000000 0000000000000080 00
8 1 7ff0000000000001 0000000000000000 0000000000000100 00
8 1 7ff8000000000000 0000000000000000 0000000000000200 00
8 0 000000003f800000 0000000000000000 0000000000000200 00
f 1 3ff0000000000000 4000000000000000 0000000000000000 00

// ==== vlog.f ====
logic/fpu_pkg.sv
logic/fpu_if.sv
logic/fpu_dispatch.sv
logic/fpu_noncomp_lane.sv
logic/fpu_result_merge.sv
logic/fpu_noncomp_top.sv
testbench/fpu_noncomp_assertions.sv
testbench/tb_fpu_noncomp.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f vlog.f --top-module tb_fpu_noncomp \
  -Mdir obj_dir -o sim_tb_fpu_noncomp

./obj_dir/sim_tb_fpu_noncomp > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported a failure"
  exit 1
fi

// ==== testbench/tb_fpu_noncomp.sv ====
module tb_fpu_noncomp;

  localparam int          CLK_PERIOD      = 100;
  localparam int          RESET_CYCLES    = 4;
  localparam int          CYCLES_PER_TEST = 20;
  localparam int          CYCLE_MARGIN    = 100;
  localparam int          DRIVE_DELAY     = 10;
  localparam logic [15:0] LFSR_SEED       = 16'd33;
  localparam string       TEST_FILE       = "testbench/fpu_noncomp_tests.txt";

  logic              i_clk;
  logic              i_reset_n;
  logic              i_valid;
  logic              o_ready;
  fpu_pkg::op_t      i_op;
  fpu_pkg::fmt_t     i_fmt;
  fpu_pkg::xlen_t    i_rs1;
  fpu_pkg::xlen_t    i_rs2;
  logic              o_valid;
  logic              i_ready;
  fpu_pkg::xlen_t    o_result;
  fpu_pkg::fflags_t  o_fflags;

  // test vectors as read from the file
  fpu_pkg::op_t      test_op [$];
  fpu_pkg::fmt_t     test_fmt [$];
  fpu_pkg::xlen_t    test_rs1 [$];
  fpu_pkg::xlen_t    test_rs2 [$];
  fpu_pkg::xlen_t    test_res [$];
  fpu_pkg::fflags_t  test_flags [$];

  // expected results of accepted requests in order of acceptance
  fpu_pkg::xlen_t    exp_res_q [$];
  fpu_pkg::fflags_t  exp_flags_q [$];

  logic [15:0]       lfsr_state;
  int                sent;
  int                checked;
  int                cycle_count;
  int                cycle_limit;
  logic              in_fire;
  logic              out_fire;
  logic              held;
  fpu_pkg::xlen_t    held_result;
  fpu_pkg::fflags_t  held_flags;

  fpu_noncomp_top i_fpu_noncomp_top (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_valid),
    .o_ready   (o_ready),
    .i_op      (i_op),
    .i_fmt     (i_fmt),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .o_valid   (o_valid),
    .i_ready   (i_ready),
    .o_result  (o_result),
    .o_fflags  (o_fflags)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_rand_bit();
    logic fb;
    fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic load_tests();
    int                fd;
    int                code;
    string             line;
    fpu_pkg::op_t      op;
    fpu_pkg::fmt_t     fmt;
    fpu_pkg::xlen_t    rs1;
    fpu_pkg::xlen_t    rs2;
    fpu_pkg::xlen_t    res;
    fpu_pkg::fflags_t  flags;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("Error: the test vector file could not be opened");
      $display("Test failed");
      $fatal(1, "no test file");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        code = $sscanf(line, "%h %h %h %h %h %h", op, fmt, rs1, rs2, res, flags);
        if (code != 6) begin
          $display("Error: a line of the test vector file could not be parsed");
          $display("Test failed");
          $fatal(1, "bad test line");
        end else begin
          test_op.push_back(op);
          test_fmt.push_back(fmt);
          test_rs1.push_back(rs1);
          test_rs2.push_back(rs2);
          test_res.push_back(res);
          test_flags.push_back(flags);
        end
      end
    end
    $fclose(fd);
  endtask

  // runs just after a rising edge
  task automatic drive_cycle();
    logic [1:0] rnd;
    if (in_fire) begin
      i_valid = 1'b0;  // previous request taken
    end
    if (!i_valid && sent < test_op.size()) begin
      rnd = {next_rand_bit(), next_rand_bit()};
      if (rnd != 2'b00) begin  // gap one time in four
        i_valid = 1'b1;
        i_op    = test_op[sent];
        i_fmt   = test_fmt[sent];
        i_rs1   = test_rs1[sent];
        i_rs2   = test_rs2[sent];
      end
    end
    rnd     = {next_rand_bit(), next_rand_bit()};
    i_ready = (rnd != 2'b00);  // stall one time in four
  endtask

  // runs on the falling edge when all outputs have settled
  task automatic monitor_cycle();
    in_fire  = i_valid && o_ready;
    out_fire = o_valid && i_ready;
    if (held) begin
      check_value("o_valid during stall", 64'(o_valid), 64'(1));
      check_value("o_result during stall", o_result, held_result);
      check_value("o_fflags during stall", 64'(o_fflags), 64'(held_flags));
    end
    if (out_fire) begin
      if (exp_res_q.size() == 0) begin
        $display("Error at time %0t: a result came out with no request outstanding", $time);
        $display("Test failed");
        $fatal(1, "unexpected output");
      end else begin
        check_value($sformatf("o_result of test %0d", checked), o_result,
                    exp_res_q.pop_front());
        check_value($sformatf("o_fflags of test %0d", checked), 64'(o_fflags),
                    64'(exp_flags_q.pop_front()));
        checked++;
      end
    end
    held        = o_valid && !i_ready;
    held_result = o_result;
    held_flags  = o_fflags;
    if (in_fire) begin
      exp_res_q.push_back(test_res[sent]);
      exp_flags_q.push_back(test_flags[sent]);
      sent++;
    end
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Error: the run timed out after %0d cycles", cycle_count);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    i_reset_n   = 1'b0;
    i_valid     = 1'b0;
    i_op        = '0;
    i_fmt       = fpu_pkg::FMT_S;
    i_rs1       = '0;
    i_rs2       = '0;
    i_ready     = 1'b0;
    lfsr_state  = LFSR_SEED;
    sent        = 0;
    checked     = 0;
    cycle_count = 0;
    cycle_limit = 0;
    in_fire     = 1'b0;
    out_fire    = 1'b0;
    held        = 1'b0;
    held_result = '0;
    held_flags  = '0;
    load_tests();
    if (test_op.size() == 0) begin
      $display("Error: the test vector file holds no tests");
      $display("Test failed");
      $fatal(1, "empty test file");
    end
    cycle_limit = test_op.size() * CYCLES_PER_TEST + CYCLE_MARGIN;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #DRIVE_DELAY;
    i_reset_n = 1'b1;
    @(negedge i_clk);
    check_value("o_valid after reset", 64'(o_valid), 64'(0));
    check_value("o_ready after reset", 64'(o_ready), 64'(1));
    while (checked < test_op.size()) begin
      @(posedge i_clk);
      #DRIVE_DELAY;
      drive_cycle();
      @(negedge i_clk);
      monitor_cycle();
    end
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_valid = 1'b0;
    @(negedge i_clk);
    check_value("o_valid when drained", 64'(o_valid), 64'(0));
    if (exp_res_q.size() == 0 && sent == test_op.size()) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Error: requests remain outstanding at the end of the run");
      $display("Test failed");
      $fatal(1, "leftover requests");
    end
  end

endmodule

// ==== testbench/fpu_noncomp_assertions.sv ====
module fpu_noncomp_assertions (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              o_valid,
  input  logic              i_ready,
  input  fpu_pkg::xlen_t    o_result,
  input  fpu_pkg::fflags_t  o_fflags
);

  localparam fpu_pkg::fflags_t NV_MASK = fpu_pkg::fflags_t'(1) << fpu_pkg::FFLAG_NV;

  // nothing to deliver right out of reset
  property valid_low_after_reset;
    @(posedge i_clk) $rose(i_reset_n) |-> !o_valid;
  endproperty

  property output_held_on_stall;
    @(posedge i_clk) disable iff (!i_reset_n)
      (o_valid && !i_ready) |=> (o_valid && $stable(o_result) && $stable(o_fflags));
  endproperty

  property only_nv_raised;
    @(posedge i_clk) disable iff (!i_reset_n)
      o_valid |-> ((o_fflags & ~NV_MASK) == '0);  // no DZ OF UF NX here
  endproperty

  a_valid_low_after_reset : assert property (valid_low_after_reset)
    else $error("o_valid was high in the first cycle after reset");

  a_output_held_on_stall : assert property (output_held_on_stall)
    else $error("output changed while stalled by i_ready");

  a_only_nv_raised : assert property (only_nv_raised)
    else $error("a flag other than NV was raised");

endmodule

bind fpu_noncomp_top fpu_noncomp_assertions u_assertions (.*);

// ==== logic/fpu_noncomp_top.sv ====
module fpu_noncomp_top (
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_valid,
  output logic               o_ready,
  input  fpu_pkg::op_t       i_op,
  input  fpu_pkg::fmt_t      i_fmt,
  input  fpu_pkg::xlen_t     i_rs1,
  input  fpu_pkg::xlen_t     i_rs2,

  output logic               o_valid,
  input  logic               i_ready,
  output fpu_pkg::xlen_t     o_result,
  output fpu_pkg::fflags_t   o_fflags
);

  fpu_req_if req_if [fpu_pkg::LANE_COUNT] ();
  fpu_rsp_if rsp_if [fpu_pkg::LANE_COUNT] ();

  fpu_dispatch u_dispatch (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_valid    (i_valid),
    .o_ready    (o_ready),
    .i_op       (i_op),
    .i_fmt      (i_fmt),
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .lane_req_o (req_if)
  );

  for (genvar g = 0; g < fpu_pkg::LANE_COUNT; g++) begin : g_lane
    fpu_noncomp_lane u_lane (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .req_i     (req_if[g]),
      .rsp_o     (rsp_if[g])
    );
  end

  fpu_result_merge u_merge (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .lane_rsp_i (rsp_if),
    .o_valid    (o_valid),
    .i_ready    (i_ready),
    .o_result   (o_result),
    .o_fflags   (o_fflags)
  );

endmodule

// ==== logic/fpu_result_merge.sv ====
module fpu_result_merge (
  input  logic               i_clk,
  input  logic               i_reset_n,
  fpu_rsp_if.receiver        lane_rsp_i [fpu_pkg::LANE_COUNT],
  output logic               o_valid,
  input  logic               i_ready,
  output fpu_pkg::xlen_t     o_result,
  output fpu_pkg::fflags_t   o_fflags
);

  fpu_pkg::lane_idx_t              rd_ptr;
  logic [fpu_pkg::LANE_COUNT-1:0]  lane_valid;
  fpu_pkg::xlen_t                  lane_result [fpu_pkg::LANE_COUNT];
  fpu_pkg::fflags_t                lane_fflags [fpu_pkg::LANE_COUNT];
  logic                            pop;

  for (genvar g = 0; g < fpu_pkg::LANE_COUNT; g++) begin : g_lane
    assign lane_valid[g]  = lane_rsp_i[g].valid;
    assign lane_result[g] = lane_rsp_i[g].result;
    assign lane_fflags[g] = lane_rsp_i[g].fflags;
    // only the oldest lane may drain
    assign lane_rsp_i[g].ready = i_ready && (rd_ptr == fpu_pkg::lane_idx_t'(g));
  end

  assign o_valid  = lane_valid[rd_ptr];
  assign o_result = lane_result[rd_ptr];
  assign o_fflags = lane_fflags[rd_ptr];
  assign pop      = o_valid && i_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      rd_ptr <= '0;
    end else if (pop) begin
      if (rd_ptr == fpu_pkg::lane_idx_t'(fpu_pkg::LANE_COUNT - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;  // follow issue order
      end
    end
  end

endmodule

// ==== logic/fpu_noncomp_lane.sv ====
module fpu_noncomp_lane (
  input  logic          i_clk,
  input  logic          i_reset_n,
  fpu_req_if.receiver   req_i,
  fpu_rsp_if.sender     rsp_o
);

  // one-hot class in RISC-V FCLASS order
  function automatic fpu_pkg::class_mask_t classify(input fpu_pkg::xlen_t val,
                                                    input fpu_pkg::fmt_t fmt);
    logic                 sign;
    logic                 exp_ones;
    logic                 exp_zero;
    logic                 man_zero;
    logic                 quiet;
    fpu_pkg::class_mask_t mask;
    if (fmt == fpu_pkg::FMT_S) begin
      sign     = val[31];
      exp_ones = &val[30:23];
      exp_zero = ~|val[30:23];
      man_zero = ~|val[22:0];
      quiet    = val[22];
    end else begin
      sign     = val[63];
      exp_ones = &val[62:52];
      exp_zero = ~|val[62:52];
      man_zero = ~|val[51:0];
      quiet    = val[51];
    end
    mask = '0;
    if (exp_ones && !man_zero) begin
      mask[quiet ? 9 : 8] = 1'b1;  // qNaN / sNaN
    end else if (exp_ones) begin
      mask[sign ? 0 : 7] = 1'b1;   // infinity
    end else if (exp_zero && man_zero) begin
      mask[sign ? 3 : 4] = 1'b1;   // zero
    end else if (exp_zero) begin
      mask[sign ? 2 : 5] = 1'b1;   // subnormal
    end else begin
      mask[sign ? 1 : 6] = 1'b1;   // normal
    end
    return mask;
  endfunction

  // a single without all ones above bit 31 reads as canonical NaN
  function automatic fpu_pkg::xlen_t unbox(input fpu_pkg::xlen_t val,
                                           input fpu_pkg::fmt_t fmt);
    fpu_pkg::xlen_t res;
    if (fmt == fpu_pkg::FMT_D) begin
      res = val;
    end else if (&val[63:32]) begin
      res = {32'h0, val[31:0]};
    end else begin
      res = {32'h0, fpu_pkg::CANON_NAN_S};
    end
    return res;
  endfunction

  fpu_pkg::xlen_t        opa;
  fpu_pkg::xlen_t        opb;
  fpu_pkg::class_mask_t  cls_a;
  fpu_pkg::class_mask_t  cls_b;
  logic                  sign_a;
  logic                  sign_b;
  logic [62:0]           mag_a;
  logic [62:0]           mag_b;
  logic                  a_nan;
  logic                  b_nan;
  logic                  a_snan;
  logic                  b_snan;
  logic                  any_nan;
  logic                  both_zero;
  logic                  eq_num;
  logic                  lt_num;
  logic                  lt_tot;
  logic                  sgn_new;
  fpu_pkg::xlen_t        canon_nan;
  fpu_pkg::xlen_t        res_d;
  fpu_pkg::xlen_t        res_boxed;
  fpu_pkg::fflags_t      flags_d;
  logic                  box_res;
  logic                  accept;
  logic                  full_q;
  fpu_pkg::xlen_t        result_q;
  fpu_pkg::fflags_t      fflags_q;

  assign opa   = unbox(req_i.rs1, req_i.fmt);
  assign opb   = unbox(req_i.rs2, req_i.fmt);
  assign cls_a = classify(opa, req_i.fmt);
  assign cls_b = classify(opb, req_i.fmt);

  assign sign_a = (req_i.fmt == fpu_pkg::FMT_S) ? opa[31] : opa[63];
  assign sign_b = (req_i.fmt == fpu_pkg::FMT_S) ? opb[31] : opb[63];
  assign mag_a  = (req_i.fmt == fpu_pkg::FMT_S) ? {32'h0, opa[30:0]} : opa[62:0];
  assign mag_b  = (req_i.fmt == fpu_pkg::FMT_S) ? {32'h0, opb[30:0]} : opb[62:0];

  assign a_nan     = cls_a[8] | cls_a[9];
  assign b_nan     = cls_b[8] | cls_b[9];
  assign a_snan    = cls_a[8];
  assign b_snan    = cls_b[8];
  assign any_nan   = a_nan | b_nan;
  assign both_zero = (cls_a[3] | cls_a[4]) & (cls_b[3] | cls_b[4]);

  // numeric order with +0 equal to -0
  assign eq_num = !any_nan && (both_zero || (opa == opb));
  assign lt_num = !any_nan && !both_zero &&
                  ((sign_a && !sign_b) ||
                   (!sign_a && !sign_b && (mag_a < mag_b)) ||
                   (sign_a && sign_b && (mag_a > mag_b)));
  assign lt_tot = lt_num || (both_zero && sign_a && !sign_b);  // -0 below +0 for min/max

  assign sgn_new = (req_i.op == fpu_pkg::OP_FSGNJN) ? !sign_b :
                   (req_i.op == fpu_pkg::OP_FSGNJX) ? (sign_a ^ sign_b) : sign_b;

  assign canon_nan = (req_i.fmt == fpu_pkg::FMT_D) ? fpu_pkg::CANON_NAN_D :
                     {32'h0, fpu_pkg::CANON_NAN_S};

  always_comb begin
    res_d   = '0;
    flags_d = '0;
    box_res = 1'b0;
    case (req_i.op)
      fpu_pkg::OP_FSGNJ, fpu_pkg::OP_FSGNJN, fpu_pkg::OP_FSGNJX: begin
        box_res = 1'b1;
        if (req_i.fmt == fpu_pkg::FMT_S) begin
          res_d = {32'h0, sgn_new, opa[30:0]};
        end else begin
          res_d = {sgn_new, opa[62:0]};
        end
      end
      fpu_pkg::OP_FMIN, fpu_pkg::OP_FMAX: begin
        box_res                   = 1'b1;
        flags_d[fpu_pkg::FFLAG_NV] = a_snan | b_snan;
        if (a_nan && b_nan) begin
          res_d = canon_nan;
        end else if (a_nan) begin
          res_d = opb;
        end else if (b_nan) begin
          res_d = opa;
        end else if ((req_i.op == fpu_pkg::OP_FMIN) == lt_tot) begin
          res_d = opa;  // min picks smaller, max picks larger
        end else begin
          res_d = opb;
        end
      end
      fpu_pkg::OP_FEQ: begin
        res_d                      = {63'h0, eq_num};
        flags_d[fpu_pkg::FFLAG_NV] = a_snan | b_snan;  // quiet compare
      end
      fpu_pkg::OP_FLT: begin
        res_d                      = {63'h0, lt_num};
        flags_d[fpu_pkg::FFLAG_NV] = any_nan;          // signaling compare
      end
      fpu_pkg::OP_FLE: begin
        res_d                      = {63'h0, lt_num | eq_num};
        flags_d[fpu_pkg::FFLAG_NV] = any_nan;
      end
      fpu_pkg::OP_FCLASS: begin
        res_d = {54'h0, cls_a};
      end
      default: begin
        res_d = '0;  // illegal code
      end
    endcase
  end

  assign res_boxed = (box_res && (req_i.fmt == fpu_pkg::FMT_S)) ?
                     {fpu_pkg::BOX_ONES, res_d[31:0]} : res_d;

  // one-entry holding register
  assign req_i.ready = !full_q || rsp_o.ready;
  assign accept      = req_i.valid && req_i.ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (rsp_o.ready) begin
      full_q <= 1'b0;  // taken
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      result_q <= res_boxed;
      fflags_q <= flags_d;
    end
  end

  assign rsp_o.valid  = full_q;
  assign rsp_o.result = result_q;
  assign rsp_o.fflags = fflags_q;

endmodule

// ==== logic/fpu_dispatch.sv ====
module fpu_dispatch (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_valid,
  output logic                 o_ready,
  input  fpu_pkg::op_t         i_op,
  input  fpu_pkg::fmt_t        i_fmt,
  input  fpu_pkg::xlen_t       i_rs1,
  input  fpu_pkg::xlen_t       i_rs2,
  fpu_req_if.sender            lane_req_o [fpu_pkg::LANE_COUNT]
);

  fpu_pkg::lane_idx_t               wr_ptr;
  logic [fpu_pkg::LANE_COUNT-1:0]   lane_ready;
  logic                             push;

  for (genvar g = 0; g < fpu_pkg::LANE_COUNT; g++) begin : g_lane
    // valid only toward the lane under the write pointer
    assign lane_req_o[g].valid = i_valid && (wr_ptr == fpu_pkg::lane_idx_t'(g));
    assign lane_req_o[g].op    = i_op;
    assign lane_req_o[g].fmt   = i_fmt;
    assign lane_req_o[g].rs1   = i_rs1;
    assign lane_req_o[g].rs2   = i_rs2;
    assign lane_ready[g]       = lane_req_o[g].ready;
  end

  assign o_ready = lane_ready[wr_ptr];  // no added latency
  assign push    = i_valid && o_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      wr_ptr <= '0;
    end else if (push) begin
      if (wr_ptr == fpu_pkg::lane_idx_t'(fpu_pkg::LANE_COUNT - 1)) begin
        wr_ptr <= '0;  // wrap
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== logic/fpu_if.sv ====
interface fpu_req_if;
  logic            valid;
  logic            ready;
  fpu_pkg::op_t    op;
  fpu_pkg::fmt_t   fmt;
  fpu_pkg::xlen_t  rs1;
  fpu_pkg::xlen_t  rs2;

  modport sender (output valid, output op, output fmt, output rs1, output rs2,
                  input ready);
  modport receiver (input valid, input op, input fmt, input rs1, input rs2,
                    output ready);
endinterface

interface fpu_rsp_if;
  logic              valid;
  logic              ready;
  fpu_pkg::xlen_t    result;
  fpu_pkg::fflags_t  fflags;

  modport sender (output valid, output result, output fflags, input ready);
  modport receiver (input valid, input result, input fflags, output ready);
endinterface

// ==== logic/fpu_pkg.sv ====
package fpu_pkg;

  // at least 2 parallel lanes
  localparam int LANE_COUNT = 3;

  typedef logic [63:0] xlen_t;        // operand / result word
  typedef logic [3:0]  op_t;          // operation code
  typedef logic        fmt_t;         // precision select
  typedef logic [4:0]  fflags_t;      // NV DZ OF UF NX
  typedef logic [9:0]  class_mask_t;  // FCLASS one-hot result

  typedef logic [$clog2(LANE_COUNT)-1:0] lane_idx_t;

  // operation codes
  localparam op_t OP_FSGNJ  = 4'd0;
  localparam op_t OP_FSGNJN = 4'd1;
  localparam op_t OP_FSGNJX = 4'd2;
  localparam op_t OP_FMIN   = 4'd3;
  localparam op_t OP_FMAX   = 4'd4;
  localparam op_t OP_FEQ    = 4'd5;
  localparam op_t OP_FLT    = 4'd6;
  localparam op_t OP_FLE    = 4'd7;
  localparam op_t OP_FCLASS = 4'd8;

  // precision
  localparam fmt_t FMT_S = 1'b0;
  localparam fmt_t FMT_D = 1'b1;

  // invalid operation flag position in fflags
  localparam int FFLAG_NV = 4;

  // canonical quiet NaNs
  localparam logic [31:0] CANON_NAN_S = 32'h7fc0_0000;
  localparam xlen_t       CANON_NAN_D = 64'h7ff8_0000_0000_0000;

  // upper half of a properly boxed single
  localparam logic [31:0] BOX_ONES = 32'hffff_ffff;

endpackage
